//--- common/fpu_pkg.sv
package fpu_pkg;

    //////////////////////////////////////////////////
    // Operation codes
    //////////////////////////////////////////////////

    // Values 3 and 4 are reserved and unused
    typedef enum logic [3:0] {
        OP_FADD    = 4'd0,
        OP_FSUB    = 4'd1,
        OP_FMUL    = 4'd2,
        OP_FSGNJ   = 4'd5,
        OP_FSGNJN  = 4'd6,
        OP_FSGNJX  = 4'd7,
        OP_FEQ     = 4'd8,
        OP_FLE     = 4'd9,
        OP_FLT     = 4'd10,
        OP_FCVT_WS = 4'd11,
        OP_FCVT_SW = 4'd12
    } fpu_op_e;

    //////////////////////////////////////////////////
    // Single precision format
    //////////////////////////////////////////////////

    // Exponent and mantissa field widths
    localparam int EXP_W    = 8;
    localparam int MAN_W    = 23;

    // Exponent bias of the biased encoding
    localparam int EXP_BIAS = 127;

    // All-ones exponent marks infinity
    localparam int EXP_MAX  = 255;

    //////////////////////////////////////////////////
    // Unit latencies in cycles
    //////////////////////////////////////////////////

    // Add and subtract share one pipeline
    localparam int ADD_LAT  = 3;
    localparam int MUL_LAT  = 3;

    // Both conversion directions
    localparam int CVT_LAT  = 1;

endpackage

//--- fpu/fadd_pipe.sv
`timescale 1ns/1ps

module fadd_pipe (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] x1,
    input  logic [31:0] x2,
    output logic [31:0] y
);

    // Stage 1 combinational alignment
    logic [31:0]                   big;
    logic [31:0]                   lesser;
    logic [fpu_pkg::EXP_W-1:0]     diff;
    logic [fpu_pkg::MAN_W:0]       m_big;
    logic [fpu_pkg::MAN_W:0]       m_small;
    logic [fpu_pkg::MAN_W+3:0]     ext_small;
    logic [fpu_pkg::MAN_W+3:0]     al_small;

    // Stage 1 registers
    logic                          s1_sign;
    logic                          s1_sub;
    logic [fpu_pkg::EXP_W-1:0]     s1_exp;
    logic [fpu_pkg::MAN_W+3:0]     s1_mb;
    logic [fpu_pkg::MAN_W+3:0]     s1_ms;

    // Stage 2 registers
    logic                          s2_sign;
    logic [fpu_pkg::EXP_W-1:0]     s2_exp;
    logic [fpu_pkg::MAN_W+4:0]     s2_sum;

    // Stage 3 combinational normalize
    logic [4:0]                    lead;
    logic [fpu_pkg::MAN_W+4:0]     norm;
    logic signed [9:0]             e_n;
    logic [31:0]                   y_n;

    //////////////////////////////////////////////////
    // Stage 1 orders and aligns
    //////////////////////////////////////////////////

    always_comb begin
        if (x1[30:0] >= x2[30:0]) begin
            big    = x1;
            lesser = x2;
        end else begin
            big    = x2;
            lesser = x1;
        end
        diff = big[30:23] - lesser[30:23];

        // Zero exponent flushes to zero with no hidden bit
        m_big   = (big[30:23] == 8'd0) ? '0 : {1'b1, big[22:0]};
        m_small = (lesser[30:23] == 8'd0) ? '0 : {1'b1, lesser[22:0]};

        // Guard, round and sticky below the mantissa
        ext_small = {m_small, 3'b000};
        if (diff >= 8'd27) begin
            al_small    = '0;
            al_small[0] = |m_small;
        end else begin
            al_small    = ext_small >> diff;
            al_small[0] = al_small[0] | (|(ext_small & ((27'd1 << diff) - 27'd1)));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_sign <= 1'b0;
            s1_sub  <= 1'b0;
            s1_exp  <= '0;
            s1_mb   <= '0;
            s1_ms   <= '0;
        end else begin
            s1_sign <= big[31];
            s1_sub  <= big[31] ^ lesser[31];
            s1_exp  <= big[30:23];
            s1_mb   <= {m_big, 3'b000};
            s1_ms   <= al_small;
        end
    end

    //////////////////////////////////////////////////
    // Stage 2 adds or subtracts the mantissas
    //////////////////////////////////////////////////

    // Big operand is never smaller so the difference stays positive
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s2_sign <= 1'b0;
            s2_exp  <= '0;
            s2_sum  <= '0;
        end else begin
            s2_sign <= s1_sign;
            s2_exp  <= s1_exp;
            if (s1_sub) begin
                s2_sum <= {1'b0, s1_mb} - {1'b0, s1_ms};
            end else begin
                s2_sum <= {1'b0, s1_mb} + {1'b0, s1_ms};
            end
        end
    end

    //////////////////////////////////////////////////
    // Stage 3 normalizes and truncates
    //////////////////////////////////////////////////

    always_comb begin
        lead = 5'd0;
        for (int i = 0; i < 28; i++) begin
            if (s2_sum[i]) begin
                lead = 5'(i);
            end
        end

        // Leading one moves to bit 27 where a carry puts the hidden bit
        norm = s2_sum << (5'd27 - lead);
        e_n  = {2'b00, s2_exp} + {5'b00000, lead} - 10'sd26;

        if (s2_sum == '0) begin
            // Exact cancellation gives +0
            y_n = 32'd0;
        end else if (e_n >= fpu_pkg::EXP_MAX) begin
            y_n = {s2_sign, 8'(fpu_pkg::EXP_MAX), 23'd0};
        end else if (e_n <= 10'sd0) begin
            y_n = {s2_sign, 31'd0};
        end else begin
            y_n = {s2_sign, e_n[7:0], norm[26:4]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            y <= 32'd0;
        end else begin
            y <= y_n;
        end
    end

endmodule

//--- fpu/fmul_pipe.sv
`timescale 1ns/1ps

module fmul_pipe (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] x1,
    input  logic [31:0] x2,
    output logic [31:0] y
);

    logic                          s1_sign;
    logic                          s1_zero;
    logic signed [9:0]             s1_exp;
    logic [fpu_pkg::MAN_W:0]       s1_ma;
    logic [fpu_pkg::MAN_W:0]       s1_mb;

    logic                          s2_sign;
    logic                          s2_zero;
    logic signed [9:0]             s2_exp;
    logic [2*fpu_pkg::MAN_W+1:0]   s2_prod;

    logic signed [9:0]             e_n;
    logic [fpu_pkg::MAN_W-1:0]     man_n;
    logic [31:0]                   y_n;

    //////////////////////////////////////////////////
    // Stage 1: sign, exponent and zero detect
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_sign <= 1'b0;
            s1_zero <= 1'b0;
            s1_exp  <= '0;
            s1_ma   <= '0;
            s1_mb   <= '0;
        end else begin
            s1_sign <= x1[31] ^ x2[31];
            // Subnormal operands count as zero
            s1_zero <= (x1[30:23] == 8'd0) || (x2[30:23] == 8'd0);
            s1_exp  <= {2'b00, x1[30:23]} + {2'b00, x2[30:23]}
                       - 10'(fpu_pkg::EXP_BIAS);
            s1_ma   <= {1'b1, x1[22:0]};
            s1_mb   <= {1'b1, x2[22:0]};
        end
    end

    //////////////////////////////////////////////////
    // Stage 2: mantissa product
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s2_sign <= 1'b0;
            s2_zero <= 1'b0;
            s2_exp  <= '0;
            s2_prod <= '0;
        end else begin
            s2_sign <= s1_sign;
            s2_zero <= s1_zero;
            s2_exp  <= s1_exp;
            s2_prod <= s1_ma * s1_mb;
        end
    end

    //////////////////////////////////////////////////
    // Stage 3: normalize and saturate
    //////////////////////////////////////////////////

    always_comb begin
        // Product of two 1.x values lies in [1, 4)
        if (s2_prod[47]) begin
            man_n = s2_prod[46:24];
            e_n   = s2_exp + 10'sd1;
        end else begin
            man_n = s2_prod[45:23];
            e_n   = s2_exp;
        end

        if (s2_zero) begin
            y_n = {s2_sign, 31'd0};
        end else if (e_n >= fpu_pkg::EXP_MAX) begin
            y_n = {s2_sign, 8'(fpu_pkg::EXP_MAX), 23'd0};
        end else if (e_n <= 10'sd0) begin
            y_n = {s2_sign, 31'd0};
        end else begin
            y_n = {s2_sign, e_n[7:0], man_n};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            y <= 32'd0;
        end else begin
            y <= y_n;
        end
    end

endmodule

//--- logic/fsign_cmp.sv
`timescale 1ns/1ps

module fsign_cmp (
    input  fpu_pkg::fpu_op_e fpuop,
    input  logic [31:0]      x1,
    input  logic [31:0]      x2,
    output logic [31:0]      y
);

    logic [30:0] m1;
    logic [30:0] m2;
    logic        both_zero;
    logic        eq;
    logic        lt;

    // Magnitudes with subnormals flushed to zero
    assign m1 = (x1[30:23] == 8'd0) ? 31'd0 : x1[30:0];
    assign m2 = (x2[30:23] == 8'd0) ? 31'd0 : x2[30:0];

    // +0 and -0 are the same value
    assign both_zero = (m1 == 31'd0) && (m2 == 31'd0);

    assign eq = both_zero || ((x1[31] == x2[31]) && (m1 == m2));

    always_comb begin
        if (both_zero) begin
            lt = 1'b0;
        end else if (x1[31] != x2[31]) begin
            // Negative side is the smaller one
            lt = x1[31];
        end else if (x1[31]) begin
            lt = m1 > m2;
        end else begin
            lt = m1 < m2;
        end
    end

    always_comb begin
        case (fpuop)
            fpu_pkg::OP_FSGNJ:  y = {x2[31], x1[30:0]};
            fpu_pkg::OP_FSGNJN: y = {~x2[31], x1[30:0]};
            fpu_pkg::OP_FSGNJX: y = {x1[31] ^ x2[31], x1[30:0]};
            fpu_pkg::OP_FEQ:    y = {31'd0, eq};
            fpu_pkg::OP_FLE:    y = {31'd0, lt | eq};
            fpu_pkg::OP_FLT:    y = {31'd0, lt};
            default:            y = 32'd0;
        endcase
    end

endmodule

//--- logic/fcvt.sv
`timescale 1ns/1ps

module fcvt (
    input  logic        clk,
    input  logic        rstn,
    input  logic        to_float,
    input  logic [31:0] x,
    output logic [31:0] y
);

    // Float to int
    logic signed [9:0]             unb_exp;
    logic [4:0]                    shamt;
    logic [31:0]                   mag_f;
    logic [31:0]                   int_res;

    // Int to float
    logic [31:0]                   mag_i;
    logic [31:0]                   norm_i;
    logic [4:0]                    lead;
    logic [fpu_pkg::EXP_W-1:0]     f_exp;
    logic [31:0]                   float_res;

    //////////////////////////////////////////////////
    // Float to signed integer, toward zero
    //////////////////////////////////////////////////

    always_comb begin
        unb_exp = {2'b00, x[30:23]} - 10'(fpu_pkg::EXP_BIAS);
        shamt   = unb_exp[4:0];
        mag_f   = 32'd0;

        if (unb_exp < 10'sd0) begin
            // Magnitude below one truncates to zero
            int_res = 32'd0;
        end else if (unb_exp >= 10'sd31) begin
            int_res = x[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end else begin
            if (shamt >= 5'(fpu_pkg::MAN_W)) begin
                mag_f = {8'd0, 1'b1, x[22:0]} << (shamt - 5'(fpu_pkg::MAN_W));
            end else begin
                mag_f = {8'd0, 1'b1, x[22:0]} >> (5'(fpu_pkg::MAN_W) - shamt);
            end
            int_res = x[31] ? -mag_f : mag_f;
        end
    end

    //////////////////////////////////////////////////
    // Signed integer to float, toward zero
    //////////////////////////////////////////////////

    always_comb begin
        // Most negative value keeps its bit pattern as magnitude
        mag_i = x[31] ? -x : x;

        lead = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (mag_i[i]) begin
                lead = 5'(i);
            end
        end

        norm_i = mag_i << (5'd31 - lead);
        f_exp  = 8'(fpu_pkg::EXP_BIAS) + {3'b000, lead};

        if (x == 32'd0) begin
            float_res = 32'd0;
        end else begin
            float_res = {x[31], f_exp, norm_i[30 -: fpu_pkg::MAN_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            y <= 32'd0;
        end else begin
            y <= to_float ? float_res : int_res;
        end
    end

endmodule

//--- fpu/fpu.sv
`timescale 1ns/1ps

module fpu (
    input  logic              clk,
    input  logic              rstn,
    input  logic [31:0]       src0,
    input  logic [31:0]       src1,
    input  fpu_pkg::fpu_op_e  fpuop,
    output logic [31:0]       result,
    output logic              fin
);

    logic [31:0] add_x2;
    logic [31:0] add_y;
    logic [31:0] mul_y;
    logic [31:0] sc_y;
    logic [31:0] cvt_y;
    logic        to_float;
    logic [2:0]  lat;
    logic [2:0]  state;

    //////////////////////////////////////////////////
    // Arithmetic units
    //////////////////////////////////////////////////

    // Subtract is an add with the second sign flipped
    assign add_x2   = {src1[31] ^ (fpuop == fpu_pkg::OP_FSUB), src1[30:0]};
    assign to_float = (fpuop == fpu_pkg::OP_FCVT_SW);

    fadd_pipe i_fadd (
        .clk  (clk),
        .rstn (rstn),
        .x1   (src0),
        .x2   (add_x2),
        .y    (add_y)
    );

    fmul_pipe i_fmul (
        .clk  (clk),
        .rstn (rstn),
        .x1   (src0),
        .x2   (src1),
        .y    (mul_y)
    );

    fsign_cmp i_fsign_cmp (
        .fpuop (fpuop),
        .x1    (src0),
        .x2    (src1),
        .y     (sc_y)
    );

    fcvt i_fcvt (
        .clk      (clk),
        .rstn     (rstn),
        .to_float (to_float),
        .x        (src0),
        .y        (cvt_y)
    );

    //////////////////////////////////////////////////
    // Latency counter and fin
    //////////////////////////////////////////////////

    // Zero latency means the result is combinational
    always_comb begin
        case (fpuop)
            fpu_pkg::OP_FADD,
            fpu_pkg::OP_FSUB:    lat = 3'(fpu_pkg::ADD_LAT);
            fpu_pkg::OP_FMUL:    lat = 3'(fpu_pkg::MUL_LAT);
            fpu_pkg::OP_FCVT_WS,
            fpu_pkg::OP_FCVT_SW: lat = 3'(fpu_pkg::CVT_LAT);
            default:             lat = 3'd0;
        endcase
    end

    assign fin = (lat == 3'd0) ? 1'b1 : (state == lat);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= 3'd0;
        end else if (state == 3'd0) begin
            // Start counting when a multi-cycle op shows up
            if (lat != 3'd0) begin
                state <= 3'd1;
            end
        end else if (fin) begin
            state <= 3'd0;
        end else begin
            state <= state + 3'd1;
        end
    end

    // Result select
    always_comb begin
        case (fpuop)
            fpu_pkg::OP_FADD,
            fpu_pkg::OP_FSUB:    result = add_y;
            fpu_pkg::OP_FMUL:    result = mul_y;
            fpu_pkg::OP_FSGNJ,
            fpu_pkg::OP_FSGNJN,
            fpu_pkg::OP_FSGNJX,
            fpu_pkg::OP_FEQ,
            fpu_pkg::OP_FLE,
            fpu_pkg::OP_FLT:     result = sc_y;
            fpu_pkg::OP_FCVT_WS,
            fpu_pkg::OP_FCVT_SW: result = cvt_y;
            default:             result = 32'd0;
        endcase
    end

endmodule

//--- bench/fpu_tb.sv
`timescale 1ns/1ps

module fpu_tb;

    logic             clk;
    logic             rstn;
    logic [31:0]      src0;
    logic [31:0]      src1;
    fpu_pkg::fpu_op_e fpuop;
    logic [31:0]      result;
    logic             fin;

    // Trace contents with one entry per test
    string            t_name[$];
    logic [3:0]       t_op[$];
    logic [31:0]      t_a[$];
    logic [31:0]      t_b[$];
    logic [31:0]      t_exp[$];

    int               n_pass;
    int               n_fail;
    bit               loaded;

    fpu i_dut (
        .clk    (clk),
        .rstn   (rstn),
        .src0   (src0),
        .src1   (src1),
        .fpuop  (fpuop),
        .result (result),
        .fin    (fin)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Cycles from the drive edge until fin for each opcode encoding
    function automatic int expected_latency(input logic [3:0] op);
        case (op)
            4'd0, 4'd1, 4'd2: expected_latency = 3;
            4'd11, 4'd12:     expected_latency = 1;
            default:          expected_latency = 0;
        endcase
    endfunction

    task automatic read_trace();
        int          fd;
        int          cnt;
        string       line;
        string       name;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        fd = $fopen("bench/fpu_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file bench/fpu_trace.txt");
            n_fail++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                // Lines starting with # are comments
                if (line.len() > 0 && line.getc(0) != 8'h23) begin
                    cnt = $sscanf(line, "%s %h %h %h %h", name, op, a, b, e);
                    if (cnt == 5) begin
                        t_name.push_back(name);
                        t_op.push_back(op[3:0]);
                        t_a.push_back(a);
                        t_b.push_back(b);
                        t_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // fin must stay low while a multiply sits on the inputs out of reset
    task automatic check_reset_fin();
        bit ok;
        ok = 1'b1;
        @(posedge clk);
        assert (fin === 1'b0) else begin
            $display("CHECK FAILED reset_fin: expected 0, actual %b", fin);
            ok = 1'b0;
        end
        fpuop <= fpu_pkg::OP_FSGNJ;
        @(posedge clk);
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("[reset] reset_fin : %s", ok ? "ok" : "FAIL");
    endtask

    task automatic run_test(input int idx);
        int cycles;
        int want;
        bit ok;
        want   = expected_latency(t_op[idx]);
        ok     = 1'b1;
        @(posedge clk);
        fpuop <= fpu_pkg::fpu_op_e'(t_op[idx]);
        src0  <= t_a[idx];
        src1  <= t_b[idx];

        // Outputs sampled at each rising edge after the drive edge
        @(posedge clk);
        cycles = 0;
        while (!fin && cycles < 12) begin
            @(posedge clk);
            cycles++;
        end

        assert (fin) else begin
            $display("%s: fin did not rise within %0d cycles", t_name[idx], cycles);
            ok = 1'b0;
        end
        if (fin) begin
            assert (result === t_exp[idx]) else begin
                $display("CHECK FAILED %s: expected %h, actual %h",
                         t_name[idx], t_exp[idx], result);
                ok = 1'b0;
            end
            assert (cycles == want) else begin
                $display("CHECK FAILED %s latency: expected %0d, actual %0d",
                         t_name[idx], want, cycles);
                ok = 1'b0;
            end
        end

        // One combinational op in between lets the counter go idle
        fpuop <= fpu_pkg::OP_FSGNJ;
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("[%0d] %s : %s", idx, t_name[idx], ok ? "ok" : "FAIL");
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        clk    = 1'b0;
        rstn   = 1'b0;
        fpuop  = fpu_pkg::OP_FMUL;
        src0   = 32'h3fc0_0000;
        src1   = 32'h4000_0000;
        n_pass = 0;
        n_fail = 0;
        read_trace();
        if (t_name.size() == 0) begin
            $display("The trace file holds no tests");
            n_fail++;
        end
        loaded = 1'b1;

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        check_reset_fin();

        for (int i = 0; i < t_name.size(); i++) begin
            run_test(i);
        end

        $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // 8 cycles per test plus reset and settling
    initial begin
        wait (loaded);
        #((t_name.size() * 8 + 8) * 4);
        $display("Timeout: fin never arrived, run stopped at %0t", $time);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- bench/fpu_trace.txt
# Columns: name opcode src0 src1 expected, all but name in hex
# Opcodes 0 add, 1 sub, 2 mul, 5-7 sign injection, 8-a compare, b f2i, c i2f
add_eq_exp      0 3f800000 3f800000 40000000
add_diff_exp    0 40400000 3f000000 40600000
add_trunc       0 3f800000 30800000 3f800000
sub_cancel      1 3f800000 3f800000 00000000
sub_neg         1 3f800000 40400000 c0000000
add_overflow    0 7f7fffff 7f7fffff 7f800000
mul_basic       2 3fc00000 40000000 40400000
mul_neg_neg     2 bfc00000 bfc00000 40100000
mul_zero        2 00000000 c0a00000 80000000
mul_ovf_neg     2 ff000000 40000000 ff800000
mul_unf_neg     2 80800000 3f000000 80000000
sgnj_pp         5 3f800000 40000000 3f800000
sgnj_pn         5 3f800000 c0000000 bf800000
sgnj_np         5 bf800000 40000000 3f800000
sgnj_nn         5 bf800000 c0000000 bf800000
sgnjn_pp        6 3f800000 40000000 bf800000
sgnjn_pn        6 3f800000 c0000000 3f800000
sgnjn_np        6 bf800000 40000000 bf800000
sgnjn_nn        6 bf800000 c0000000 3f800000
sgnjx_pp        7 3f800000 40000000 3f800000
sgnjx_pn        7 3f800000 c0000000 bf800000
sgnjx_np        7 bf800000 40000000 bf800000
sgnjx_nn        7 bf800000 c0000000 3f800000
feq_same        8 3f800000 3f800000 00000001
feq_zeros       8 00000000 80000000 00000001
fle_zeros       9 80000000 00000000 00000001
flt_zeros       a 00000000 80000000 00000000
flt_mixed       a bf800000 3f800000 00000001
fle_mixed       9 3f800000 bf800000 00000000
flt_both_neg    a c0000000 bf800000 00000001
f2i_frac        b 40300000 00000000 00000002
f2i_neg         b c0600000 00000000 fffffffd
f2i_sat         b 4f800000 00000000 7fffffff
i2f_trunc       c 01000001 00000000 4b800000
i2f_max         c 7fffffff 00000000 4effffff
i2f_zero        c 00000000 00000000 00000000
i2f_minint      c 80000000 00000000 cf000000
unused_op       3 3f800000 3f800000 00000000

//--- fpu.f
common/fpu_pkg.sv
fpu/fadd_pipe.sv
fpu/fmul_pipe.sv
logic/fsign_cmp.sv
logic/fcvt.sv
fpu/fpu.sv
bench/fpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module fpu_tb -f fpu.f -o fpu_sim
./obj_dir/fpu_sim > sim.log 2>&1
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
else
    exit 1
fi
